//--- vlog.f
src/kbd_pkg.sv
src/ps2_byte_decoder.sv
src/key_status_tracker.sv
src/keymap_translator.sv
src/spectrum_keyboard.sv
testbench/spectrum_keyboard_sva.sv
testbench/tb_spectrum_keyboard.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_spectrum_keyboard
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_spectrum_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spectrum_keyboard;

  // Host addresses 0 to 767 cover keymap entries 0x000 to 0x17f in both tables
  localparam int table_bytes     = 768;
  localparam int host_op_count   = 2 * table_bytes + 2;
  localparam int ps2_byte_count  = 23;
  localparam int settle_cycles   = 10;
  localparam int watchdog_cycles = (ps2_byte_count + host_op_count) * 20 + 2000;

  localparam logic [6:0] key_a       = 7'h1c;
  localparam logic [6:0] key_b       = 7'h32;
  localparam logic [6:0] key_j       = 7'h3b;
  localparam logic [6:0] key_up      = 7'h75;
  localparam logic [6:0] code_lshift = 7'h12;

  logic               clk;
  logic               rst;
  logic [7:0]         ps2_byte;
  logic               ps2_req;
  kbd_pkg::host_cmd_t host_cmd;
  logic               host_req;
  logic [7:0]         sp_row;
  logic               ps2_ack;
  logic               host_ack;
  logic [7:0]         host_rdata;
  logic [4:0]         sp_col;

  // Reference model of the tables and the Spectrum matrix
  logic [7:0]   table_img [table_bytes];
  logic [4:0]   model_rows [8];
  logic [255:0] model_held;
  logic [2:0]   model_mods;
  logic [4:0]   exp_col;
  logic         sweep_en;
  logic         rd_check;
  logic [7:0]   rd_expect;
  integer       seed;

  spectrum_keyboard u_spectrum_keyboard (
    .clk        (clk),
    .rst        (rst),
    .ps2_byte   (ps2_byte),
    .ps2_req    (ps2_req),
    .host_cmd   (host_cmd),
    .host_req   (host_req),
    .sp_row     (sp_row),
    .ps2_ack    (ps2_ack),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .sp_col     (sp_col)
  );

  bind spectrum_keyboard spectrum_keyboard_sva u_spectrum_keyboard_sva (
    .clk      (clk),
    .rst      (rst),
    .ps2_req  (ps2_req),
    .ps2_ack  (ps2_ack),
    .host_req (host_req),
    .host_ack (host_ack),
    .sp_col   (sp_col)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // A selected half-row pulls its pressed columns low, selections combine by AND
  always_comb begin
    exp_col = 5'h1f;
    for (int r = 0; r < 8; r++) begin
      if (!sp_row[r]) begin
        exp_col = exp_col & model_rows[r];
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
    stop_with_failure($sformatf("FAIL at %0t: %s expected %h got %h", $time, name,
                                expected, actual));
  endtask

  matrix_matches: assert property (@(posedge clk) disable iff (rst) sweep_en |-> sp_col == exp_col)
    else report_mismatch("sp_col", {3'b000, $sampled(exp_col)}, {3'b000, $sampled(sp_col)});

  acks_quiet: assert property (@(posedge clk) disable iff (rst)
                               sweep_en |-> (!ps2_ack && !host_ack))
    else stop_with_failure("An ack was high while no handshake was in progress");

  rdata_matches: assert property (@(posedge clk) disable iff (rst)
                                  rd_check |-> host_rdata == rd_expect)
    else report_mismatch("host_rdata", $sampled(rd_expect), $sampled(host_rdata));

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_failure("Timeout, the run did not finish within the watchdog limit");
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  task automatic send_byte(input logic [7:0] b);
    ps2_byte <= b;
    ps2_req  <= 1'b1;
    do @(posedge clk); while (!ps2_ack);
    ps2_req <= 1'b0;
    do @(posedge clk); while (ps2_ack);
  endtask

  task automatic host_op(input kbd_pkg::host_op_t op, input logic [7:0] data,
                         input logic check, input logic [7:0] expected);
    host_cmd.op   <= op;
    host_cmd.data <= data;
    host_req      <= 1'b1;
    do @(posedge clk); while (!host_ack);
    host_req  <= 1'b0;
    rd_check  <= check;
    rd_expect <= expected;
    do begin
      @(posedge clk);
      rd_check <= 1'b0;
    end while (host_ack);
  endtask

  // Sweeps sp_row while the matrix and ack checks are armed
  task automatic sweep_rows(input logic full);
    logic [31:0] rnd;
    sweep_en <= 1'b1;
    if (full) begin
      for (int p = 0; p < 256; p++) begin
        sp_row <= p[7:0];
        @(posedge clk);
      end
    end else begin
      for (int r = 0; r < 8; r++) begin
        sp_row <= ~(8'h01 << r);
        @(posedge clk);
      end
      sp_row <= 8'h00;
      @(posedge clk);
      rnd = $random(seed);
      sp_row <= rnd[7:0];
      @(posedge clk);
    end
    sweep_en <= 1'b0;
    sp_row   <= 8'hff;
  endtask

  task automatic apply_entry(input logic [7:0] entry, input logic up);
    if (up) begin
      model_rows[entry[7:5]] = model_rows[entry[7:5]] | entry[4:0];
    end else begin
      model_rows[entry[7:5]] = model_rows[entry[7:5]] & ~entry[4:0];
    end
  endtask

  // Sends one key event, updates the model and checks the matrix once settled
  task automatic key_event(input logic ext, input logic rel, input logic [6:0] code);
    logic [10:0] idx;
    logic [7:0]  id;
    idx = {model_mods, ext, code};
    id  = {ext, code};
    if (ext) send_byte(kbd_pkg::prefix_ext);
    if (rel) send_byte(kbd_pkg::prefix_break);
    send_byte({1'b0, code});
    apply_entry(table_img[2 * idx], rel);
    apply_entry(table_img[2 * idx + 1], rel);
    model_held[id] = ~rel;
    if (id == kbd_pkg::key_lshift || id == kbd_pkg::key_rshift) model_mods[0] = ~rel;
    if (id == kbd_pkg::key_lctrl || id == kbd_pkg::key_rctrl) model_mods[1] = ~rel;
    if (id == kbd_pkg::key_lalt || id == kbd_pkg::key_ralt) model_mods[2] = ~rel;
    if (model_held == '0) begin
      for (int r = 0; r < 8; r++) model_rows[r] = 5'h1f;
    end
    repeat (settle_cycles) @(posedge clk);
    sweep_rows(1'b0);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] rnd;
    seed       = 2;
    rst        = 1'b1;
    ps2_byte   = 8'h00;
    ps2_req    = 1'b0;
    host_cmd   = '0;
    host_req   = 1'b0;
    sp_row     = 8'hff;
    sweep_en   = 1'b0;
    rd_check   = 1'b0;
    rd_expect  = 8'h00;
    model_held = '0;
    model_mods = 3'b000;
    for (int r = 0; r < 8; r++) model_rows[r] = 5'h1f;
    for (int h = 0; h < table_bytes; h++) begin
      rnd = $random(seed);
      table_img[h] = rnd[7:0];
    end

    // All rows are selected during the second reset cycle
    @(posedge clk);
    sp_row <= 8'h00;
    @(posedge clk);
    rst    <= 1'b0;
    sp_row <= 8'hff;
    @(posedge clk);
    sweep_rows(1'b1);

    // Even host addresses land in table one, odd ones in table two
    host_op(kbd_pkg::op_rewind, 8'h00, 1'b0, 8'h00);
    for (int h = 0; h < table_bytes; h++) host_op(kbd_pkg::op_write, table_img[h], 1'b0, 8'h00);
    host_op(kbd_pkg::op_rewind, 8'h00, 1'b0, 8'h00);
    for (int h = 0; h < table_bytes; h++) host_op(kbd_pkg::op_read, 8'h00, 1'b1, table_img[h]);

    key_event(1'b0, 1'b0, key_a);
    key_event(1'b0, 1'b1, key_a);

    // Shifted lookup, the shift key itself looks up under the older modifiers
    key_event(1'b0, 1'b0, code_lshift);
    key_event(1'b0, 1'b0, key_b);
    key_event(1'b0, 1'b1, key_b);
    key_event(1'b0, 1'b1, code_lshift);

    key_event(1'b1, 1'b0, key_up);
    key_event(1'b1, 1'b1, key_up);

    // The shifted entry of A stays pressed until J is let go as well
    key_event(1'b0, 1'b0, key_j);
    key_event(1'b0, 1'b0, code_lshift);
    key_event(1'b0, 1'b0, key_a);
    key_event(1'b0, 1'b1, code_lshift);
    key_event(1'b0, 1'b1, key_a);
    key_event(1'b0, 1'b1, key_j);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/spectrum_keyboard_sva.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_keyboard_sva (
  input logic       clk,
  input logic       rst,
  input logic       ps2_req,
  input logic       ps2_ack,
  input logic       host_req,
  input logic       host_ack,
  input logic [4:0] sp_col
);

  // --------------------------------------------------
  // Four-phase handshakes
  // --------------------------------------------------
  ps2_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
                                      $rose(ps2_ack) |-> ps2_req)
    else $error("ps2_ack rose while ps2_req was low");

  host_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
                                       $rose(host_ack) |-> host_req)
    else $error("host_ack rose while host_req was low");

  // Ack may only drop once the request has already gone
  ps2_ack_falls_late: assert property (@(posedge clk) disable iff (rst)
                                       $fell(ps2_ack) |-> !$past(ps2_req))
    else $error("ps2_ack fell before ps2_req was released");

  host_ack_falls_late: assert property (@(posedge clk) disable iff (rst)
                                        $fell(host_ack) |-> !$past(host_req))
    else $error("host_ack fell before host_req was released");

  // No key reads as pressed while in reset
  reset_matrix_released: assert property (@(posedge clk) rst |-> sp_col == 5'h1f)
    else $error("sp_col showed a pressed key during reset");

endmodule

`default_nettype wire

//--- src/spectrum_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_keyboard (
  input  logic               clk,
  input  logic               rst,
  input  logic [7:0]         ps2_byte,
  input  logic               ps2_req,
  input  kbd_pkg::host_cmd_t host_cmd,
  input  logic               host_req,
  input  logic [7:0]         sp_row,
  output logic               ps2_ack,
  output logic               host_ack,
  output logic [7:0]         host_rdata,
  output logic [4:0]         sp_col
);

  kbd_pkg::scan_event_t scan_event;
  logic                 event_valid;
  logic                 event_ready;
  logic [2:0]           modifiers;
  logic                 kb_clean;

  // --------------------------------------------------
  // PS/2 byte stream into scan events
  // --------------------------------------------------
  ps2_byte_decoder u_ps2_byte_decoder (
    .clk         (clk),
    .rst         (rst),
    .ps2_byte    (ps2_byte),
    .ps2_req     (ps2_req),
    .event_ready (event_ready),
    .ps2_ack     (ps2_ack),
    .scan_event  (scan_event),
    .event_valid (event_valid)
  );

  key_status_tracker u_key_status_tracker (
    .clk         (clk),
    .rst         (rst),
    .scan_event  (scan_event),
    .event_valid (event_valid),
    .modifiers   (modifiers),
    .kb_clean    (kb_clean)
  );

  // Keymap lookup drives the Spectrum matrix and serves the host
  keymap_translator u_keymap_translator (
    .clk         (clk),
    .rst         (rst),
    .scan_event  (scan_event),
    .event_valid (event_valid),
    .modifiers   (modifiers),
    .kb_clean    (kb_clean),
    .host_cmd    (host_cmd),
    .host_req    (host_req),
    .sp_row      (sp_row),
    .event_ready (event_ready),
    .host_ack    (host_ack),
    .host_rdata  (host_rdata),
    .sp_col      (sp_col)
  );

endmodule

`default_nettype wire

//--- src/keymap_translator.sv
`timescale 1ns/1ps
`default_nettype none

module keymap_translator (
  input  logic                 clk,
  input  logic                 rst,
  input  kbd_pkg::scan_event_t scan_event,
  input  logic                 event_valid,
  input  logic [2:0]           modifiers,
  input  logic                 kb_clean,
  input  kbd_pkg::host_cmd_t   host_cmd,
  input  logic                 host_req,
  input  logic [7:0]           sp_row,
  output logic                 event_ready,
  output logic                 host_ack,
  output logic [7:0]           host_rdata,
  output logic [4:0]           sp_col
);

  typedef enum logic [2:0] {
    st_clean,
    st_idle,
    st_lookup,
    st_key_one,
    st_key_two,
    st_host,
    st_host_wait
  } state_t;

  state_t state;

  // Two keymap tables, each entry names one Spectrum key
  kbd_pkg::keymap_entry_u table_one [2048];
  kbd_pkg::keymap_entry_u table_two [2048];
  kbd_pkg::keymap_entry_u entry_one;
  kbd_pkg::keymap_entry_u entry_two;

  // Spectrum half-rows, a zero bit is a pressed key
  logic [4:0] rows [8];

  logic        key_pending;
  logic [10:0] pend_addr;
  logic        pend_released;
  logic [10:0] key_addr;
  logic        key_released;
  logic [10:0] event_addr;

  logic [11:0] host_addr;
  logic [10:0] host_idx;
  logic        host_rewound;

  assign event_addr = {modifiers, scan_event.extended, scan_event.code};
  assign host_idx   = host_addr[11:1];

  assign event_ready = (state == st_idle || state == st_clean) && !key_pending && !event_valid;

  function automatic logic [4:0] apply_key(logic [4:0] row, logic [4:0] mask, logic up);
    if (up) begin
      return row | mask;
    end
    return row & ~mask;
  endfunction

  // --------------------------------------------------
  // Control FSM and key matrix
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      key_pending  <= 1'b0;
      host_ack     <= 1'b0;
      host_addr    <= '0;
      host_rewound <= 1'b0;
      for (int i = 0; i < 8; i++) begin
        rows[i] <= '1;
      end
    end else begin
      // An event landing outside idle waits here for its turn
      if (event_valid && state != st_idle) begin
        key_pending <= 1'b1;
      end
      case (state)
        st_clean: begin
          for (int i = 0; i < 8; i++) begin
            rows[i] <= '1;
          end
          state <= st_idle;
        end
        st_idle: begin
          if (event_valid || key_pending) begin
            key_pending <= 1'b0;
            state       <= st_lookup;
          end else if (host_req) begin
            state <= st_host;
          end else if (kb_clean) begin
            state <= st_clean;
          end
        end
        st_lookup: begin
          state <= st_key_one;
        end
        st_key_one: begin
          rows[entry_one.key.row] <= apply_key(rows[entry_one.key.row],
                                               entry_one.key.col_mask, key_released);
          state <= st_key_two;
        end
        st_key_two: begin
          // An empty mask leaves the row as it was
          rows[entry_two.key.row] <= apply_key(rows[entry_two.key.row],
                                               entry_two.key.col_mask, key_released);
          state <= st_idle;
        end
        st_host: begin
          host_ack     <= 1'b1;
          host_rewound <= (host_cmd.op == kbd_pkg::op_rewind);
          if (host_cmd.op == kbd_pkg::op_rewind) begin
            host_addr <= '0;
          end
          state <= st_host_wait;
        end
        st_host_wait: begin
          if (!host_req) begin
            host_ack <= 1'b0;
            if (!host_rewound) begin
              host_addr <= host_addr + 12'd1;
            end
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Event capture, table lookup and host data path
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (event_valid) begin
      pend_addr     <= event_addr;
      pend_released <= scan_event.released;
    end
    // Modifiers are taken as they stood when the event arrived
    if (state == st_idle) begin
      key_addr     <= event_valid ? event_addr : pend_addr;
      key_released <= event_valid ? scan_event.released : pend_released;
    end
    if (state == st_lookup) begin
      entry_one <= table_one[key_addr];
      entry_two <= table_two[key_addr];
    end
    if (state == st_host) begin
      if (host_cmd.op == kbd_pkg::op_read) begin
        host_rdata <= host_addr[0] ? table_two[host_idx].raw : table_one[host_idx].raw;
      end
      if (host_cmd.op == kbd_pkg::op_write) begin
        if (host_addr[0]) begin
          table_two[host_idx].raw <= host_cmd.data;
        end else begin
          table_one[host_idx].raw <= host_cmd.data;
        end
      end
    end
  end

  // Every selected half-row pulls its pressed columns low
  always_comb begin
    sp_col = '1;
    for (int r = 0; r < 8; r++) begin
      if (!sp_row[r]) begin
        sp_col = sp_col & rows[r];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/key_status_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module key_status_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  kbd_pkg::scan_event_t scan_event,
  input  logic                 event_valid,
  output logic [2:0]           modifiers,
  output logic                 kb_clean
);

  // One bit per {extended, code}, set while the key is down
  logic [255:0] held;
  logic [7:0]   key_id;
  logic         down;

  assign key_id = {scan_event.extended, scan_event.code};
  assign down   = ~scan_event.released;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= '0;
    end else if (event_valid) begin
      held[key_id] <= down;
    end
  end

  // Clean flag trails the held map by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      kb_clean <= 1'b1;
    end else begin
      kb_clean <= ~|held;
    end
  end

  // --------------------------------------------------
  // Modifiers, ordered {alt, ctrl, shift}
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      modifiers <= 3'b000;
    end else if (event_valid) begin
      case (key_id)
        kbd_pkg::key_lshift, kbd_pkg::key_rshift: begin
          modifiers[0] <= down;
        end
        kbd_pkg::key_lctrl, kbd_pkg::key_rctrl: begin
          modifiers[1] <= down;
        end
        kbd_pkg::key_lalt, kbd_pkg::key_ralt: begin
          modifiers[2] <= down;
        end
        default: begin
          modifiers <= modifiers;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ps2_byte_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_byte_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [7:0]           ps2_byte,
  input  logic                 ps2_req,
  input  logic                 event_ready,
  output logic                 ps2_ack,
  output kbd_pkg::scan_event_t scan_event,
  output logic                 event_valid
);

  logic is_ext;
  logic is_break;
  logic is_prefix;
  logic take;
  logic ext_pending;
  logic break_pending;
  logic emit;

  assign is_ext    = (ps2_byte == kbd_pkg::prefix_ext);
  assign is_break  = (ps2_byte == kbd_pkg::prefix_break);
  assign is_prefix = is_ext | is_break;

  // Prefix bytes are always taken, a completing byte waits for the translator
  assign take = ps2_req & ~ps2_ack & (is_prefix | event_ready);

  // --------------------------------------------------
  // Handshake and prefix state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ps2_ack       <= 1'b0;
      ext_pending   <= 1'b0;
      break_pending <= 1'b0;
      emit          <= 1'b0;
      event_valid   <= 1'b0;
    end else begin
      // Ack is held until the sender lets go of req
      ps2_ack     <= take | (ps2_ack & ps2_req);
      emit        <= take & ~is_prefix;
      event_valid <= emit;
      if (take) begin
        if (is_ext) begin
          ext_pending <= 1'b1;
        end else if (is_break) begin
          break_pending <= 1'b1;
        end else begin
          ext_pending   <= 1'b0;
          break_pending <= 1'b0;
        end
      end
    end
  end

  // The event word stays put until the next completing byte
  always_ff @(posedge clk) begin
    if (take && !is_prefix) begin
      scan_event.extended <= ext_pending;
      scan_event.released <= break_pending;
      scan_event.code     <= ps2_byte[6:0];
    end
  end

endmodule

`default_nettype wire

//--- src/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

  // --------------------------------------------------
  // PS/2 side
  // --------------------------------------------------

  // One decoded key event, code keeps the low seven bits of the scan byte
  typedef struct packed {
    logic       extended;
    logic       released;
    logic [6:0] code;
  } scan_event_t;

  localparam logic [7:0] prefix_ext   = 8'he0;
  localparam logic [7:0] prefix_break = 8'hf0;

  // Modifier keys as {extended, code}
  localparam logic [7:0] key_lshift = 8'h12;
  localparam logic [7:0] key_rshift = 8'h59;
  localparam logic [7:0] key_lctrl  = 8'h14;
  localparam logic [7:0] key_rctrl  = 8'h94;
  localparam logic [7:0] key_lalt   = 8'h11;
  localparam logic [7:0] key_ralt   = 8'h91;

  // --------------------------------------------------
  // Host keymap port
  // --------------------------------------------------

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_rewind
  } host_op_t;

  typedef struct packed {
    host_op_t   op;
    logic [7:0] data;
  } host_cmd_t;

  // The host sees a plain byte, the matrix update sees a half-row and a column mask
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] row;
      logic [4:0] col_mask;
    } key;
  } keymap_entry_u;

endpackage

`default_nettype wire
